/* vlog.f */
common/histPkg.sv
hw/sampleReceiver.sv
histogram/frameSequencer.sv
histogram/binAccumulator.sv
histogram/peakTracker.sv
hw/windowCalc.sv
hw/histPeakTop.sv
verification/clockGen.sv
verification/histPeakTb_assert.sv
verification/histPeakTb.sv

/* run.sh */
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module histPeakTb -o histPeakSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/histPeakSim)
simStatus=$?
printf '%s\n' "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* verification/histPeakTb.sv */
`timescale 1ns/1ps

module histPeakTb;

    localparam int PIXEL_NUM         = histPkg::PIXEL_NUM_DEF;
    localparam int SAMPLES_PER_PIXEL = histPkg::SAMPLES_PER_PIXEL_DEF;
    localparam int ACQ_NUM           = histPkg::ACQ_NUM_DEF;
    localparam int BIN_BITS          = histPkg::BIN_BITS_DEF;
    localparam int COUNT_BITS        = histPkg::COUNT_BITS_DEF;
    localparam int POS_BITS          = histPkg::POS_BITS_DEF;
    localparam int CLK_PERIOD        = 20;
    localparam int BIN_NUM           = 1 << BIN_BITS;
    // samples of one pixel in one frame
    localparam int PIX_LEN           = SAMPLES_PER_PIXEL * ACQ_NUM;
    localparam int FRAME_LEN         = PIXEL_NUM * PIX_LEN;
    // frames run by all tests together
    localparam int FRAME_COUNT       = 11;
    localparam int WATCHDOG_CYCLES   = FRAME_COUNT * FRAME_LEN * 40 + 2000;
    localparam int WAIT_LIMIT        = 200;

    logic                 clk;
    logic                 combin_res;
    logic                 sampleReq;
    logic [BIN_BITS-1:0]  sampleBin;
    logic                 sampleAck;
    logic                 resReq;
    logic                 resAck;
    histPkg::peakResult_t resData;

    // stimulus of one frame in arrival order
    int frameBins [FRAME_LEN];
    // model peaks per pixel
    int expBin [PIXEL_NUM];
    int expCount [PIXEL_NUM];
    // set while a sample request must stay unanswered
    bit holdCheck;
    int errorCount;

    clockGen #(.PERIOD(CLK_PERIOD)) uClk (.clk(clk));

    histPeakTop #(
        .PIXEL_NUM(PIXEL_NUM), .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL), .ACQ_NUM(ACQ_NUM),
        .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .POS_BITS(POS_BITS)
    ) uut (
        .clk(clk), .combin_res(combin_res), .sampleReq(sampleReq), .sampleBin(sampleBin),
        .sampleAck(sampleAck), .resReq(resReq), .resData(resData), .resAck(resAck)
    );

    task automatic checkValue(input string what, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic reportHang(input string what);
        $display("handshake stalled: no %s within %0d cycles", what, WAIT_LIMIT);
        $display("TEST FAILED");
        $fatal(1, "handshake stalled");
    endtask

    // position of sample k of a pixel within one acquisition
    function automatic int sampleIndex(input int acq, input int pix, input int k);
        return (acq * PIXEL_NUM + pix) * SAMPLES_PER_PIXEL + k;
    endfunction

    // n counts the pixel's samples across the whole frame
    task automatic setPixelSample(input int pix, input int n, input int bin);
        frameBins[sampleIndex(n / SAMPLES_PER_PIXEL, pix, n % SAMPLES_PER_PIXEL)] = bin;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (holdCheck) begin
                checkValue("sampleAck while closed", int'(sampleAck), 0);
            end
        end
    endtask

    task automatic waitAck(input logic level, output int cycles);
        cycles = 0;
        while (sampleAck !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                reportHang("sampleAck change");
            end
        end
    endtask

    task automatic waitResult(input logic level);
        int cycles;
        cycles = 0;
        while (resReq !== level) begin
            idleCycles(1);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                reportHang("resReq change");
            end
        end
    endtask

    // one four-phase sample transfer
    task automatic sendSample(input int bin);
        int n;
        @(negedge clk);
        sampleReq = 1'b1;
        sampleBin = BIN_BITS'(bin);
        waitAck(1'b1, n);
        @(negedge clk);
        sampleReq = 1'b0;
        waitAck(1'b0, n);
    endtask

    task automatic sendFrame(input int startIdx);
        for (int i = startIdx; i < FRAME_LEN; i++) begin
            sendSample(frameBins[i]);
        end
    endtask

    // histogram in arrival order, strictly greater moves the peak
    task automatic buildModel();
        int cnt [PIXEL_NUM][BIN_NUM];
        int bin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expBin[p] = 0;
            expCount[p] = 0;
            for (int b = 0; b < BIN_NUM; b++) begin
                cnt[p][b] = 0;
            end
        end
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                    bin = frameBins[sampleIndex(a, p, s)];
                    cnt[p][bin]++;
                    if (cnt[p][bin] > expCount[p]) begin
                        expCount[p] = cnt[p][bin];
                        expBin[p] = bin;
                    end
                end
            end
        end
    endtask

    // coarse window with edge clamping
    task automatic computeWindow(input int bin, output int lo, output int hi);
        int half;
        int centre;
        int posMax;
        half = 1 << (BIN_BITS - 1);
        centre = bin << (POS_BITS - BIN_BITS);
        posMax = (1 << POS_BITS) - 1;
        if (centre <= half) begin
            lo = 0;
            hi = 2 * half;
        end else if (centre >= posMax - half) begin
            hi = posMax;
            lo = posMax - 2 * half;
        end else begin
            lo = centre - half;
            hi = centre + half;
        end
    endtask

    // collect one result per pixel, ack after a random wait
    task automatic readResults(input int maxDelay);
        int lo;
        int hi;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            waitResult(1'b1);
            computeWindow(expBin[p], lo, hi);
            checkValue("result pixel", int'(resData.pixel), p);
            checkValue("peak bin", int'(resData.peakBin), expBin[p]);
            checkValue("peak count", int'(resData.peakCount), expCount[p]);
            checkValue("lower bound", int'(resData.lowerBound), lo);
            checkValue("upper bound", int'(resData.upperBound), hi);
            idleCycles($urandom_range(maxDelay, 0) + 1);
            resAck = 1'b1;
            waitResult(1'b0);
            @(negedge clk);
            resAck = 1'b0;
        end
    endtask

    task automatic runFrame(input int maxDelay);
        sendFrame(0);
        buildModel();
        readResults(maxDelay);
    endtask

    task automatic resetAndFirstSample();
        checkValue("sampleAck after reset", int'(sampleAck), 0);
        checkValue("resReq after reset", int'(resReq), 0);
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameBins[i] = 5;
        end
        // first transfer must complete on its own
        sendSample(frameBins[0]);
        sendFrame(1);
        buildModel();
        readResults(0);
    endtask

    // even samples on p+2, odd ones split between 7 and 9
    task automatic patternFrame();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int n = 0; n < PIX_LEN; n++) begin
                setPixelSample(p, n, (n % 2 == 0) ? (p + 2) % BIN_NUM : ((n % 4 == 1) ? 7 : 9));
            end
        end
        runFrame(2);
    endtask

    // low edge, top bin, middle, and just above the low edge
    task automatic windowEdges();
        int peaks [4];
        peaks = '{0, BIN_NUM - 1, BIN_NUM / 2, 1};
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int n = 0; n < PIX_LEN; n++) begin
                setPixelSample(p, n, (n == 0) ? (peaks[p % 4] + 3) % BIN_NUM : peaks[p % 4]);
            end
        end
        runFrame(1);
    endtask

    task automatic readoutBackPressure();
        int nextBin;
        int n;
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameBins[i] = $urandom_range(BIN_NUM - 1, 0);
        end
        sendFrame(0);
        buildModel();
        // next frame's first sample queued behind the readout
        nextBin = $urandom_range(BIN_NUM - 1, 0);
        @(negedge clk);
        sampleReq = 1'b1;
        sampleBin = BIN_BITS'(nextBin);
        holdCheck = 1'b1;
        readResults(6);
        holdCheck = 1'b0;
        waitAck(1'b1, n);
        // readoutDone and the clear cycle come first
        if (n <= 2) begin
            $display("sample accepted %0d cycles after readout, before the clear ended", n);
            $display("TEST FAILED");
            $fatal(1, "early acknowledge");
        end
        @(negedge clk);
        sampleReq = 1'b0;
        waitAck(1'b0, n);
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameBins[i] = $urandom_range(BIN_NUM - 1, 0);
        end
        frameBins[0] = nextBin;
        sendFrame(1);
        buildModel();
        readResults(3);
    endtask

    // bin 3 would still lead if counts leaked between frames
    task automatic secondFrameClear();
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameBins[i] = 3;
        end
        runFrame(1);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int n = 0; n < PIX_LEN; n++) begin
                setPixelSample(p, n, (n == 0) ? 3 : (BIN_NUM - 6) + (n % 2));
            end
        end
        runFrame(1);
    endtask

    // two bins per pixel with equal totals, shuffled
    task automatic randomTies();
        int x;
        int y;
        int nx;
        int ny;
        for (int f = 0; f < 4; f++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                x = $urandom_range(BIN_NUM - 1, 0);
                y = (x + 1 + $urandom_range(BIN_NUM - 2, 0)) % BIN_NUM;
                nx = PIX_LEN / 2;
                ny = PIX_LEN - nx;
                for (int n = 0; n < PIX_LEN; n++) begin
                    if (ny == 0 || (nx > 0 && $urandom_range(1, 0) == 0)) begin
                        setPixelSample(p, n, x);
                        nx--;
                    end else begin
                        setPixelSample(p, n, y);
                        ny--;
                    end
                end
            end
            runFrame(4);
        end
    endtask

    // run limit from the frame budget
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        void'($urandom(74400));
        errorCount = 0;
        holdCheck = 1'b0;
        combin_res = 1'b0;
        sampleReq = 1'b0;
        sampleBin = '0;
        resAck = 1'b0;
        repeat (10) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        resetAndFirstSample();
        patternFrame();
        windowEdges();
        readoutBackPressure();
        secondFrameClear();
        randomTies();
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/histPeakTb_assert.sv */
`timescale 1ns/1ps

module histPeakTb_assert (
    input logic                 clk,
    input logic                 combin_res,
    input logic                 sampleReq,
    input logic                 sampleAck,
    input logic                 resReq,
    input logic                 resAck,
    input histPkg::peakResult_t resData
);

    // ack only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(sampleAck) |-> sampleReq)
        else $error("sampleAck rose without sampleReq");

    // offered result frozen until taken
    resultHeld: assert property (@(posedge clk) disable iff (!combin_res)
        (resReq && !resAck) |=> $stable(resData))
        else $error("resData changed while waiting for resAck");

    // window never inverted
    boundsOrdered: assert property (@(posedge clk) disable iff (!combin_res)
        resReq |-> (resData.lowerBound <= resData.upperBound))
        else $error("lower bound above upper bound");

endmodule

bind histPeakTop histPeakTb_assert uChk (
    .clk(clk), .combin_res(combin_res), .sampleReq(sampleReq), .sampleAck(sampleAck),
    .resReq(resReq), .resAck(resAck), .resData(resData)
);

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* hw/histPeakTop.sv */
`timescale 1ns/1ps

module histPeakTop #(
    parameter int PIXEL_NUM         = histPkg::PIXEL_NUM_DEF,
    parameter int SAMPLES_PER_PIXEL = histPkg::SAMPLES_PER_PIXEL_DEF,
    parameter int ACQ_NUM           = histPkg::ACQ_NUM_DEF,
    parameter int BIN_BITS          = histPkg::BIN_BITS_DEF,
    parameter int COUNT_BITS        = histPkg::COUNT_BITS_DEF,
    parameter int POS_BITS          = histPkg::POS_BITS_DEF
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 sampleReq,
    input  logic [BIN_BITS-1:0]  sampleBin,
    output logic                 sampleAck,
    output logic                 resReq,
    output histPkg::peakResult_t resData,
    input  logic                 resAck
);

    // receiver to sequencer and accumulator
    logic                                 collectOpen;
    logic                                 sampleStrobe;
    logic [BIN_BITS-1:0]                  capturedBin;
    // sequencer control
    logic [7:0]                           pixelIndex;
    logic                                 clearBins;
    histPkg::seqState_t                   state;
    logic                                 readoutDone;
    // accumulator to peak tracker
    logic                                 countValid;
    logic [BIN_BITS-1:0]                  countBin;
    logic [7:0]                           countPixel;
    logic [COUNT_BITS-1:0]                countValue;
    // peak tracker to window calculator
    logic [PIXEL_NUM-1:0][BIN_BITS-1:0]   peakBins;
    logic [PIXEL_NUM-1:0][COUNT_BITS-1:0] peakCounts;

    sampleReceiver #(.BIN_BITS(BIN_BITS)) uRx (
        .clk(clk), .combin_res(combin_res), .sampleReq(sampleReq), .sampleBin(sampleBin),
        .collectOpen(collectOpen), .sampleAck(sampleAck), .sampleStrobe(sampleStrobe),
        .capturedBin(capturedBin)
    );

    frameSequencer #(
        .PIXEL_NUM(PIXEL_NUM), .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL), .ACQ_NUM(ACQ_NUM)
    ) uSeq (
        .clk(clk), .combin_res(combin_res), .sampleStrobe(sampleStrobe),
        .readoutDone(readoutDone), .collectOpen(collectOpen), .pixelIndex(pixelIndex),
        .frameEnd(), .clearBins(clearBins), .state(state)
    );

    binAccumulator #(
        .PIXEL_NUM(PIXEL_NUM), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)
    ) uAcc (
        .clk(clk), .combin_res(combin_res), .sampleStrobe(sampleStrobe),
        .capturedBin(capturedBin), .pixelIndex(pixelIndex), .clearBins(clearBins),
        .countValid(countValid), .countBin(countBin), .countPixel(countPixel),
        .countValue(countValue)
    );

    peakTracker #(
        .PIXEL_NUM(PIXEL_NUM), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)
    ) uPeak (
        .clk(clk), .combin_res(combin_res), .countValid(countValid), .countBin(countBin),
        .countPixel(countPixel), .countValue(countValue), .clearBins(clearBins),
        .peakBins(peakBins), .peakCounts(peakCounts)
    );

    windowCalc #(
        .PIXEL_NUM(PIXEL_NUM), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS),
        .POS_BITS(POS_BITS)
    ) uWin (
        .clk(clk), .combin_res(combin_res), .state(state), .peakBins(peakBins),
        .peakCounts(peakCounts), .resAck(resAck), .resReq(resReq), .resData(resData),
        .readoutDone(readoutDone)
    );

endmodule

/* hw/windowCalc.sv */
`timescale 1ns/1ps

module windowCalc #(
    parameter int PIXEL_NUM  = histPkg::PIXEL_NUM_DEF,
    parameter int BIN_BITS   = histPkg::BIN_BITS_DEF,
    parameter int COUNT_BITS = histPkg::COUNT_BITS_DEF,
    parameter int POS_BITS   = histPkg::POS_BITS_DEF
) (
    input  logic                                 clk,
    input  logic                                 combin_res,
    input  histPkg::seqState_t                   state,
    input  logic [PIXEL_NUM-1:0][BIN_BITS-1:0]   peakBins,
    input  logic [PIXEL_NUM-1:0][COUNT_BITS-1:0] peakCounts,
    input  logic                                 resAck,
    output logic                                 resReq,
    output histPkg::peakResult_t                 resData,
    output logic                                 readoutDone
);

    // offer, wait for ack low, then idle until the frame moves on
    typedef enum logic [1:0] {OUT_OFFER, OUT_RELEASE, OUT_DONE} outState_t;

    // half a bin in position units, window is two halves wide
    localparam logic [POS_BITS-1:0] HALF_WIDTH = POS_BITS'(1) << (BIN_BITS - 1);
    localparam logic [POS_BITS-1:0] FULL_WIDTH = POS_BITS'(1) << BIN_BITS;
    localparam logic [POS_BITS-1:0] POS_MAX    = '1;

    outState_t             outState;
    logic [7:0]            pixIdx;
    logic                  inReadout;
    logic [BIN_BITS-1:0]   curBin;
    logic [COUNT_BITS-1:0] curCount;
    logic [POS_BITS-1:0]   centre;
    logic [POS_BITS-1:0]   lowerBound;
    logic [POS_BITS-1:0]   upperBound;

    assign inReadout = (state == histPkg::READOUT);
    assign curBin    = peakBins[pixIdx];
    assign curCount  = peakCounts[pixIdx];
    // bin index scaled up to position units
    assign centre    = POS_BITS'(curBin) << (POS_BITS - BIN_BITS);

    always_comb begin
        if (centre <= HALF_WIDTH) begin
            // pinned to the low edge
            lowerBound = '0;
            upperBound = FULL_WIDTH;
        end else if (centre >= POS_MAX - HALF_WIDTH) begin
            // pinned to the high edge
            upperBound = POS_MAX;
            lowerBound = POS_MAX - FULL_WIDTH;
        end else begin
            lowerBound = centre - HALF_WIDTH;
            upperBound = centre + HALF_WIDTH;
        end
    end

    // result word, stable while pixIdx holds
    always_comb begin
        resData.pixel      = pixIdx;
        resData.peakBin    = 8'(curBin);
        resData.peakCount  = 8'(curCount);
        resData.lowerBound = 8'(lowerBound);
        resData.upperBound = 8'(upperBound);
    end

    assign resReq = inReadout && (outState == OUT_OFFER);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            outState    <= OUT_OFFER;
            pixIdx      <= '0;
            readoutDone <= 1'b0;
        end else begin
            readoutDone <= 1'b0;
            case (outState)
                OUT_OFFER: begin
                    if (inReadout && resAck) begin
                        outState <= OUT_RELEASE;
                    end
                end
                // next pixel only after ack is back low
                OUT_RELEASE: begin
                    if (!resAck) begin
                        if (pixIdx == 8'(PIXEL_NUM - 1)) begin
                            pixIdx      <= '0;
                            readoutDone <= 1'b1;
                            outState    <= OUT_DONE;
                        end else begin
                            pixIdx   <= pixIdx + 1'b1;
                            outState <= OUT_OFFER;
                        end
                    end
                end
                default: begin
                    if (!inReadout) begin
                        outState <= OUT_OFFER;
                    end
                end
            endcase
        end
    end

endmodule

/* histogram/peakTracker.sv */
`timescale 1ns/1ps

module peakTracker #(
    parameter int PIXEL_NUM  = histPkg::PIXEL_NUM_DEF,
    parameter int BIN_BITS   = histPkg::BIN_BITS_DEF,
    parameter int COUNT_BITS = histPkg::COUNT_BITS_DEF
) (
    input  logic                                  clk,
    input  logic                                  combin_res,
    input  logic                                  countValid,
    input  logic [BIN_BITS-1:0]                   countBin,
    input  logic [7:0]                            countPixel,
    input  logic [COUNT_BITS-1:0]                 countValue,
    input  logic                                  clearBins,
    output logic [PIXEL_NUM-1:0][BIN_BITS-1:0]    peakBins,
    output logic [PIXEL_NUM-1:0][COUNT_BITS-1:0]  peakCounts
);

    // one running maximum per pixel
    for (genvar p = 0; p < PIXEL_NUM; p++) begin : gPixel
        logic [BIN_BITS-1:0]   maxBin;
        logic [COUNT_BITS-1:0] maxCount;
        logic                  newPeak;

        // strictly greater, so the first bin to reach a tie keeps it
        assign newPeak = countValid && (countPixel == 8'(p)) && (countValue > maxCount);

        always_ff @(posedge clk or negedge combin_res) begin
            if (!combin_res) begin
                maxBin   <= '0;
                maxCount <= '0;
            end else if (clearBins) begin
                maxBin   <= '0;
                maxCount <= '0;
            end else if (newPeak) begin
                maxBin   <= countBin;
                maxCount <= countValue;
            end
        end

        assign peakBins[p]   = maxBin;
        assign peakCounts[p] = maxCount;
    end

endmodule

/* histogram/binAccumulator.sv */
`timescale 1ns/1ps

module binAccumulator #(
    parameter int PIXEL_NUM  = histPkg::PIXEL_NUM_DEF,
    parameter int BIN_BITS   = histPkg::BIN_BITS_DEF,
    parameter int COUNT_BITS = histPkg::COUNT_BITS_DEF
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  sampleStrobe,
    input  logic [BIN_BITS-1:0]   capturedBin,
    input  logic [7:0]            pixelIndex,
    input  logic                  clearBins,
    output logic                  countValid,
    output logic [BIN_BITS-1:0]   countBin,
    output logic [7:0]            countPixel,
    output logic [COUNT_BITS-1:0] countValue
);

    localparam int BIN_NUM = 1 << BIN_BITS;
    localparam int DEPTH   = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // one histogram per pixel, laid out pixel by pixel
    logic [COUNT_BITS-1:0] countMem [DEPTH];
    // stale counts are ignored instead of wiped
    logic [DEPTH-1:0]      entryValid;
    logic [ADDR_W-1:0]     entryAddr;
    logic [COUNT_BITS-1:0] nextCount;
    logic                  doWrite;

    assign entryAddr = ADDR_W'(int'(pixelIndex) * BIN_NUM + int'(capturedBin));
    assign doWrite   = sampleStrobe && !clearBins;

    // first hit of a frame starts at one
    assign nextCount = entryValid[entryAddr] ? countMem[entryAddr] + 1'b1
                                             : COUNT_BITS'(1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
            countValid <= 1'b0;
        end else begin
            countValid <= doWrite;
            if (clearBins) begin
                // whole memory invalid in one cycle
                entryValid <= '0;
            end else if (sampleStrobe) begin
                entryValid[entryAddr] <= 1'b1;
            end
        end
    end

    // count write and forward to the peak tracker
    always_ff @(posedge clk) begin
        if (doWrite) begin
            countMem[entryAddr] <= nextCount;
            countValue          <= nextCount;
            countBin            <= capturedBin;
            countPixel          <= pixelIndex;
        end
    end

endmodule

/* histogram/frameSequencer.sv */
`timescale 1ns/1ps

module frameSequencer #(
    parameter int PIXEL_NUM         = histPkg::PIXEL_NUM_DEF,
    parameter int SAMPLES_PER_PIXEL = histPkg::SAMPLES_PER_PIXEL_DEF,
    parameter int ACQ_NUM           = histPkg::ACQ_NUM_DEF
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               sampleStrobe,
    input  logic               readoutDone,
    output logic               collectOpen,
    output logic [7:0]         pixelIndex,
    output logic               frameEnd,
    output logic               clearBins,
    output histPkg::seqState_t state
);

    localparam int SAMPLE_W = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int ACQ_W    = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [SAMPLE_W-1:0] sampleCnt;
    logic [7:0]          pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;
    logic                countEn;
    logic                lastSample;
    logic                lastPixel;
    logic                lastAcq;
    logic                frameDone;
    // second drain cycle flag
    logic                drainCnt;

    assign countEn    = sampleStrobe && (state == histPkg::COLLECT);
    assign lastSample = (sampleCnt == SAMPLE_W'(SAMPLES_PER_PIXEL - 1));
    assign lastPixel  = (pixelCnt == 8'(PIXEL_NUM - 1));
    assign lastAcq    = (acqCnt == ACQ_W'(ACQ_NUM - 1));
    assign frameDone  = countEn && lastSample && lastPixel && lastAcq;

    assign collectOpen = (state == histPkg::COLLECT);
    assign clearBins   = (state == histPkg::CLEAR);
    assign pixelIndex  = pixelCnt;

    // samples inside pixel inside acquisition, pixel 0 first
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (countEn) begin
            if (!lastSample) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!lastPixel) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    // all counters wrap together at frame end
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= histPkg::COLLECT;
            frameEnd <= 1'b0;
            drainCnt <= 1'b0;
        end else begin
            frameEnd <= 1'b0;
            drainCnt <= 1'b0;
            case (state)
                histPkg::COLLECT: begin
                    if (frameDone) begin
                        state    <= histPkg::DRAIN;
                        frameEnd <= 1'b1;
                    end
                end
                // two cycles, count write then peak update
                histPkg::DRAIN: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state <= histPkg::READOUT;
                    end
                end
                histPkg::READOUT: begin
                    if (readoutDone) begin
                        state <= histPkg::CLEAR;
                    end
                end
                default: state <= histPkg::COLLECT;
            endcase
        end
    end

endmodule

/* hw/sampleReceiver.sv */
`timescale 1ns/1ps

module sampleReceiver #(
    parameter int BIN_BITS = histPkg::BIN_BITS_DEF
) (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleReq,
    input  logic [BIN_BITS-1:0] sampleBin,
    input  logic                collectOpen,
    output logic                sampleAck,
    output logic                sampleStrobe,
    output logic [BIN_BITS-1:0] capturedBin
);

    // idle until a request is taken, acked until it is withdrawn
    typedef enum logic {RX_IDLE, RX_ACKED} rxState_t;

    rxState_t rxState;
    logic     accept;

    // take a request only while the sequencer collects
    assign accept = (rxState == RX_IDLE) && sampleReq && collectOpen;

    // ack follows the state, so it drops right after req goes low
    assign sampleAck = (rxState == RX_ACKED);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rxState      <= RX_IDLE;
            sampleStrobe <= 1'b0;
        end else begin
            // single strobe per four-phase transfer
            sampleStrobe <= accept;
            if (accept) begin
                rxState <= RX_ACKED;
            end else if ((rxState == RX_ACKED) && !sampleReq) begin
                rxState <= RX_IDLE;
            end
        end
    end

    // bin is stable while req is high, latch it with the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            capturedBin <= sampleBin;
        end
    end

endmodule

/* common/histPkg.sv */
package histPkg;

    // default frame geometry, overridden from the top level
    // pixels served by one histogram memory
    localparam int PIXEL_NUM_DEF = 4;

    // bin addresses each pixel sends per acquisition
    localparam int SAMPLES_PER_PIXEL_DEF = 3;

    // acquisitions folded into one frame
    localparam int ACQ_NUM_DEF = 2;

    // bin address width, 16 bins per pixel
    localparam int BIN_BITS_DEF = 4;

    // width of one bin counter
    localparam int COUNT_BITS_DEF = 8;

    // position resolution of the search window
    localparam int POS_BITS_DEF = 8;

    // frame flow
    // COLLECT  samples accepted and binned
    // DRAIN    accumulator and peak pipeline settle
    // READOUT  one result per pixel on the output handshake
    // CLEAR    all bins invalidated in one cycle
    typedef enum logic [1:0] {
        COLLECT,
        DRAIN,
        READOUT,
        CLEAR
    } seqState_t;

    // one result word per pixel
    // fields sized for the largest supported geometry
    typedef struct packed {
        logic [7:0] pixel;
        logic [7:0] peakBin;
        logic [7:0] peakCount;
        // coarse window in position units
        logic [7:0] lowerBound;
        logic [7:0] upperBound;
    } peakResult_t;

endpackage
